/* hdl/bram_bank.sv */
//********************
// One 32-bit block RAM bank
//********************

`default_nettype none

module bram_bank (
	input  wire logic                                  i_clock,
	input  wire logic                                  i_rst_n,
	input  wire logic                                  i_request,
	input  wire logic                                  i_rw,
	input  wire logic [soc_map_pkg::BANK_ADDR_W-1:0]   i_offset,
	input  wire logic [soc_bus_pkg::DATA_W-1:0]        i_wdata,
	output logic      [soc_bus_pkg::DATA_W-1:0]        o_rdata,
	output logic                                       o_ready
);

	logic [soc_bus_pkg::DATA_W-1:0] mem [soc_map_pkg::BANK_WORDS];
	logic accept;

	// No new access while the previous ready is still out
	assign accept = i_request && !o_ready;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ready <= 1'b0;
		end else begin
			o_ready <= accept;
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			if (i_rw == soc_bus_pkg::BUS_WRITE) begin
				mem[i_offset] <= i_wdata;
			end else begin
				o_rdata <= mem[i_offset];
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/bus_decoder.sv */
//********************
// Address decoder for the master bus
//********************

`default_nettype none

module bus_decoder (
	input  wire logic                                      i_request,
	input  wire logic                                      i_rw,
	input  wire logic [soc_bus_pkg::ADDR_W-1:0]            i_address,
	output logic      [soc_map_pkg::NUM_BANKS-1:0]         o_bank_request,
	output logic      [soc_map_pkg::BANK_ADDR_W-1:0]       o_bank_offset,
	output logic                                           o_sram_request,
	output logic      [soc_map_pkg::SRAM_ADDR_W-2:0]       o_sram_offset,
	output logic                                           o_led_request,
	output logic                                           o_unmapped,
	output logic      [soc_map_pkg::NUM_BANKS-1:0]         o_select_bank,
	output logic                                           o_select_sram
);

	logic [soc_bus_pkg::ADDR_W-1:0] bank_rel;
	logic [soc_bus_pkg::ADDR_W-1:0] sram_rel;
	logic [soc_bus_pkg::ADDR_W-1:0] led_rel;
	logic [$clog2(soc_map_pkg::NUM_BANKS)-1:0] bank_idx;
	logic bank_hit;
	logic sram_hit;
	logic led_hit;
	logic is_write;

	// Offsets from each base, an address below a base wraps and misses
	assign bank_rel = i_address - soc_map_pkg::BANK_BASE;
	assign sram_rel = i_address - soc_map_pkg::SRAM_BASE;
	assign led_rel = i_address - soc_map_pkg::LED_BASE;

	assign bank_hit = bank_rel < soc_map_pkg::NUM_BANKS * soc_map_pkg::BANK_WORDS * 4;
	assign sram_hit = sram_rel < soc_map_pkg::SRAM_WORDS * 4;
	assign led_hit = led_rel < soc_map_pkg::LED_SPAN;
	assign is_write = i_rw == soc_bus_pkg::BUS_WRITE;

	assign bank_idx = bank_rel[soc_map_pkg::BANK_ADDR_W + 2 +: $clog2(soc_map_pkg::NUM_BANKS)];
	assign o_bank_offset = bank_rel[2 +: soc_map_pkg::BANK_ADDR_W];
	assign o_sram_offset = sram_rel[2 +: soc_map_pkg::SRAM_ADDR_W - 1];

	always_comb begin
		for (int k = 0; k < soc_map_pkg::NUM_BANKS; k++) begin
			o_select_bank[k] = bank_hit && (bank_idx == k);
		end
	end

	assign o_bank_request = i_request ? o_select_bank : '0;
	assign o_select_sram = sram_hit;
	assign o_sram_request = i_request && sram_hit;

	// LED register is write only, a LED read goes to the zero responder
	assign o_led_request = i_request && led_hit && is_write;
	assign o_unmapped = i_request && !bank_hit && !sram_hit && !(led_hit && is_write);

endmodule

`default_nettype wire

/* hdl/bus_response_mux.sv */
//********************
// Response mux back to the master
// Zero responder for unmapped accesses
//********************

`default_nettype none

module bus_response_mux (
	input  wire logic                                                     i_clock,
	input  wire logic                                                     i_rst_n,
	input  wire logic [soc_map_pkg::NUM_BANKS-1:0]                        i_select_bank,
	input  wire logic                                                     i_select_sram,
	input  wire logic [soc_map_pkg::NUM_BANKS-1:0][soc_bus_pkg::DATA_W-1:0] i_bank_rdata,
	input  wire logic [soc_map_pkg::NUM_BANKS-1:0]                        i_bank_ready,
	input  wire logic [soc_bus_pkg::DATA_W-1:0]                           i_sram_rdata,
	input  wire logic                                                     i_sram_ready,
	input  wire logic                                                     i_led_ready,
	input  wire logic                                                     i_unmapped,
	output logic      [soc_bus_pkg::DATA_W-1:0]                           o_rdata,
	output logic                                                          o_ready
);

	logic [soc_bus_pkg::DATA_W-1:0] bank_rdata;
	logic bank_ready;
	logic unmapped_ready;

	// Bank select is one-hot, zero when no bank is addressed
	always_comb begin
		bank_rdata = '0;
		bank_ready = 1'b0;
		for (int k = 0; k < soc_map_pkg::NUM_BANKS; k++) begin
			if (i_select_bank[k]) begin
				bank_rdata = i_bank_rdata[k];
				bank_ready = i_bank_ready[k];
			end
		end
	end

	// Unmapped and LED reads complete in one cycle with zero data
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_ready <= i_unmapped && !unmapped_ready;
		end
	end

	assign o_rdata = i_select_sram ? i_sram_rdata : bank_rdata;
	assign o_ready = bank_ready || (i_select_sram && i_sram_ready) || i_led_ready
		|| unmapped_ready;

endmodule

`default_nettype wire

/* hdl/led_register.sv */
//********************
// Write-only LED register
//********************

`default_nettype none

module led_register (
	input  wire logic                               i_clock,
	input  wire logic                               i_rst_n,
	input  wire logic                               i_request,
	input  wire logic [soc_bus_pkg::DATA_W-1:0]     i_wdata,
	output logic                                    o_ready,
	output logic      [soc_map_pkg::LED_W-1:0]      o_ledr
);

	logic accept;

	assign accept = i_request && !o_ready;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ready <= 1'b0;
			o_ledr <= '0;
		end else begin
			o_ready <= accept;
			// Only the low bits reach the LEDs
			if (accept) begin
				o_ledr <= i_wdata[soc_map_pkg::LED_W-1:0];
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/memory_16_to_32.sv */
//********************
// 32-bit to 16-bit access converter
// Low halfword first, then high
//********************

`default_nettype none

module memory_16_to_32 (
	input  wire logic                                  i_clock,
	input  wire logic                                  i_rst_n,
	input  wire logic                                  i_request,
	input  wire logic                                  i_rw,
	input  wire logic [soc_map_pkg::SRAM_ADDR_W-2:0]   i_offset,
	input  wire logic [soc_bus_pkg::DATA_W-1:0]        i_wdata,
	output logic      [soc_bus_pkg::DATA_W-1:0]        o_rdata,
	output logic                                       o_ready,

	output logic                                       o_ram_request,
	output logic                                       o_ram_rw,
	output logic      [soc_map_pkg::SRAM_ADDR_W-1:0]   o_ram_address,
	output logic      [soc_bus_pkg::HALF_W-1:0]        o_ram_wdata,
	input  wire logic [soc_bus_pkg::HALF_W-1:0]        i_ram_rdata,
	input  wire logic                                  i_ram_ready
);

	soc_bus_pkg::mem16_state_e state;
	logic high_half;

	assign high_half = state == soc_bus_pkg::HIGH;

	// Master holds address, rw and data until o_ready, so they feed
	// the narrow side directly
	assign o_ram_request = (state == soc_bus_pkg::LOW) || high_half;
	assign o_ram_rw = i_rw;
	assign o_ram_address = {i_offset, high_half};
	assign o_ram_wdata = high_half ? i_wdata[soc_bus_pkg::DATA_W-1:soc_bus_pkg::HALF_W]
		: i_wdata[soc_bus_pkg::HALF_W-1:0];

	assign o_ready = state == soc_bus_pkg::DONE;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= soc_bus_pkg::IDLE;
		end else begin
			case (state)
				soc_bus_pkg::IDLE: begin
					if (i_request) begin
						state <= soc_bus_pkg::LOW;
					end
				end
				soc_bus_pkg::LOW: begin
					if (i_ram_ready) begin
						state <= soc_bus_pkg::HIGH;
					end
				end
				soc_bus_pkg::HIGH: begin
					if (i_ram_ready) begin
						state <= soc_bus_pkg::DONE;
					end
				end
				// Request drops at this edge, back to idle
				default: begin
					state <= soc_bus_pkg::IDLE;
				end
			endcase
		end
	end

	// Collect read halves as they come back
	always_ff @(posedge i_clock) begin
		if (i_ram_ready && state == soc_bus_pkg::LOW) begin
			o_rdata[soc_bus_pkg::HALF_W-1:0] <= i_ram_rdata;
		end
		if (i_ram_ready && high_half) begin
			o_rdata[soc_bus_pkg::DATA_W-1:soc_bus_pkg::HALF_W] <= i_ram_rdata;
		end
	end

endmodule

`default_nettype wire

/* hdl/soc_bus_pkg.sv */
//********************
// Bus widths, bus operation encoding
// and converter state type
//********************

`default_nettype none

package soc_bus_pkg;

	// Master bus widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;

	// Narrow memory data width
	localparam int HALF_W = 16;

	// Value on the rw line
	typedef enum logic {
		BUS_READ  = 1'b0,
		BUS_WRITE = 1'b1
	} bus_op_e;

	// 16-to-32 converter states
	typedef enum logic [1:0] {
		IDLE,
		LOW,
		HIGH,
		DONE
	} mem16_state_e;

endpackage

`default_nettype wire

/* hdl/soc_bus_top.sv */
//********************
// Bus fabric top level
// Decoder, RAM banks, 16-bit memory, LEDs
//********************

`default_nettype none

module soc_bus_top (
	input  wire logic                                i_clock,
	input  wire logic                                i_rst_n,
	input  wire logic                                i_request,
	input  wire logic                                i_rw,
	input  wire logic [soc_bus_pkg::ADDR_W-1:0]      i_address,
	input  wire logic [soc_bus_pkg::DATA_W-1:0]      i_wdata,
	output logic      [soc_bus_pkg::DATA_W-1:0]      o_rdata,
	output logic                                     o_ready,
	output logic      [soc_map_pkg::LED_W-1:0]       o_ledr
);

	logic [soc_map_pkg::NUM_BANKS-1:0] bank_request;
	logic [soc_map_pkg::NUM_BANKS-1:0] select_bank;
	logic [soc_map_pkg::BANK_ADDR_W-1:0] bank_offset;
	logic [soc_map_pkg::NUM_BANKS-1:0][soc_bus_pkg::DATA_W-1:0] bank_rdata;
	logic [soc_map_pkg::NUM_BANKS-1:0] bank_ready;

	logic sram_request;
	logic select_sram;
	logic [soc_map_pkg::SRAM_ADDR_W-2:0] sram_offset;
	logic [soc_bus_pkg::DATA_W-1:0] sram_rdata;
	logic sram_ready;

	// Narrow side between converter and 16-bit memory
	logic ram16_request;
	logic ram16_rw;
	logic [soc_map_pkg::SRAM_ADDR_W-1:0] ram16_address;
	logic [soc_bus_pkg::HALF_W-1:0] ram16_wdata;
	logic [soc_bus_pkg::HALF_W-1:0] ram16_rdata;
	logic ram16_ready;

	logic led_request;
	logic led_ready;
	logic unmapped;

	bus_decoder u_decoder (
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.o_bank_request(bank_request),
		.o_bank_offset(bank_offset),
		.o_sram_request(sram_request),
		.o_sram_offset(sram_offset),
		.o_led_request(led_request),
		.o_unmapped(unmapped),
		.o_select_bank(select_bank),
		.o_select_sram(select_sram)
	);

	for (genvar g = 0; g < soc_map_pkg::NUM_BANKS; g++) begin : g_bank
		bram_bank u_bank (
			.i_clock(i_clock),
			.i_rst_n(i_rst_n),
			.i_request(bank_request[g]),
			.i_rw(i_rw),
			.i_offset(bank_offset),
			.i_wdata(i_wdata),
			.o_rdata(bank_rdata[g]),
			.o_ready(bank_ready[g])
		);
	end

	memory_16_to_32 u_mem32 (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(sram_request),
		.i_rw(i_rw),
		.i_offset(sram_offset),
		.i_wdata(i_wdata),
		.o_rdata(sram_rdata),
		.o_ready(sram_ready),
		.o_ram_request(ram16_request),
		.o_ram_rw(ram16_rw),
		.o_ram_address(ram16_address),
		.o_ram_wdata(ram16_wdata),
		.i_ram_rdata(ram16_rdata),
		.i_ram_ready(ram16_ready)
	);

	sram16_block u_sram16 (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(ram16_request),
		.i_rw(ram16_rw),
		.i_address(ram16_address),
		.i_wdata(ram16_wdata),
		.o_rdata(ram16_rdata),
		.o_ready(ram16_ready)
	);

	led_register u_led (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(led_request),
		.i_wdata(i_wdata),
		.o_ready(led_ready),
		.o_ledr(o_ledr)
	);

	bus_response_mux u_mux (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_select_bank(select_bank),
		.i_select_sram(select_sram),
		.i_bank_rdata(bank_rdata),
		.i_bank_ready(bank_ready),
		.i_sram_rdata(sram_rdata),
		.i_sram_ready(sram_ready),
		.i_led_ready(led_ready),
		.i_unmapped(unmapped),
		.o_rdata(o_rdata),
		.o_ready(o_ready)
	);

endmodule

`default_nettype wire

/* hdl/soc_map_pkg.sv */
//********************
// Address map of the bus fabric
// Bank, 16-bit memory and LED windows
//********************

`default_nettype none

package soc_map_pkg;

	// Block RAM banks, 1 KiB apart
	localparam int NUM_BANKS = 4;
	localparam int BANK_WORDS = 256;
	localparam logic [soc_bus_pkg::ADDR_W-1:0] BANK_BASE = 32'h0000_0000;
	localparam int BANK_ADDR_W = 8;

	// 16-bit memory window, counted in 32-bit words
	localparam logic [soc_bus_pkg::ADDR_W-1:0] SRAM_BASE = 32'h1000_0000;
	localparam int SRAM_WORDS = 1024;
	// Halfword address width, 2048 halfwords
	localparam int SRAM_ADDR_W = 11;

	// LED register window
	localparam logic [soc_bus_pkg::ADDR_W-1:0] LED_BASE = 32'h5000_0000;
	localparam int LED_SPAN = 16;
	localparam int LED_W = 10;

endpackage

`default_nettype wire

/* hdl/sram16_block.sv */
//********************
// On-chip 16-bit memory
// SRAM-style request/ready port
//********************

`default_nettype none

module sram16_block (
	input  wire logic                                  i_clock,
	input  wire logic                                  i_rst_n,
	input  wire logic                                  i_request,
	input  wire logic                                  i_rw,
	input  wire logic [soc_map_pkg::SRAM_ADDR_W-1:0]   i_address,
	input  wire logic [soc_bus_pkg::HALF_W-1:0]        i_wdata,
	output logic      [soc_bus_pkg::HALF_W-1:0]        o_rdata,
	output logic                                       o_ready
);

	logic [soc_bus_pkg::HALF_W-1:0] mem [2 ** soc_map_pkg::SRAM_ADDR_W];
	logic accept;

	assign accept = i_request && !o_ready;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ready <= 1'b0;
		end else begin
			o_ready <= accept;
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			if (i_rw == soc_bus_pkg::BUS_WRITE) begin
				mem[i_address] <= i_wdata;
			end else begin
				o_rdata <= mem[i_address];
			end
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the bus fabric testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module soc_bus_tb \
	-f soc_bus_top.f -o soc_bus_sim > build.log 2>&1 &&
./obj_dir/soc_bus_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2> /dev/null
grep -qx "TEST RESULT: PASS" sim.log && echo "Simulation passed" ||
	{ echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* sim/clock_gen.sv */
//********************
// Testbench clock and reset
//********************

`default_nettype none

module clock_gen (
	output logic o_clock,
	output logic o_rst_n
);

	initial o_clock = 1'b0;
	always #5 o_clock = ~o_clock;

	// Reset low for the first two rising edges
	initial begin
		o_rst_n = 1'b0;
		repeat (2) @(posedge o_clock);
		o_rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* sim/soc_bus_assert.sv */
//********************
// Bus port assertions
// Bound into soc_bus_top
//********************

`default_nettype none

module soc_bus_assert (
	input wire logic                              i_clock,
	input wire logic                              i_rst_n,
	input wire logic                              i_request,
	input wire logic                              i_ready,
	input wire logic [soc_map_pkg::LED_W-1:0]     i_ledr,
	input wire logic                              i_led_request
);

	int fail_count = 0;

	// One ready pulse per access
	ready_single: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_ready |=> !i_ready)
		else begin
			fail_count++;
			$error("o_ready high for two cycles in a row");
		end

	// Also holds for the 16-bit window, where ready comes from the DONE state
	ready_after_request: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_ready |-> $past(i_request))
		else begin
			fail_count++;
			$error("o_ready without a request in the cycle before");
		end

	led_change: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_ledr != $past(i_ledr)) |-> $past(i_led_request))
		else begin
			fail_count++;
			$error("o_ledr changed without a LED request");
		end

endmodule

bind soc_bus_top soc_bus_assert u_assert (
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_request(i_request),
	.i_ready(o_ready),
	.i_ledr(o_ledr),
	.i_led_request(led_request)
);

`default_nettype wire

/* sim/soc_bus_tb.sv */
//********************
// Bus fabric testbench
// Random traffic, reference model,
// watchdog and result line
//********************

`default_nettype none

module soc_bus_tb;

	localparam int N_BANK_OPS = 64;
	localparam int N_SRAM_OPS = 48;
	localparam int N_LED_PAIRS = 4;
	localparam int N_UNMAPPED_PAIRS = 8;
	localparam int N_MIXED_OPS = 300;
	localparam int TOTAL_ACCESSES = 2 + 8 + N_BANK_OPS + 2 + N_SRAM_OPS + 2 * N_LED_PAIRS
		+ 2 * N_UNMAPPED_PAIRS + 4 + N_MIXED_OPS;

	logic i_clock;
	logic i_rst_n;
	logic i_request;
	logic i_rw;
	logic [soc_bus_pkg::ADDR_W-1:0] i_address;
	logic [soc_bus_pkg::DATA_W-1:0] i_wdata;
	logic [soc_bus_pkg::DATA_W-1:0] o_rdata;
	logic o_ready;
	logic [soc_map_pkg::LED_W-1:0] o_ledr;

	// Reference model keyed by word address
	logic [31:0] model_mem [logic [31:0]];
	logic [soc_map_pkg::LED_W-1:0] led_model = '0;

	int error_count = 0;
	int check_count = 0;
	int access_count = 0;
	int ready_count = 0;

	clock_gen u_clock (
		.o_clock(i_clock),
		.o_rst_n(i_rst_n)
	);

	soc_bus_top dut (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_ledr(o_ledr)
	);

	always @(posedge i_clock) begin
		if (o_ready === 1'b1) begin
			ready_count <= ready_count + 1;
		end
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAIL at time %0t: %s, got %h, expected %h", $time, what, actual,
				expected);
		end
	endtask

	// One access with the request dropped at the edge that sees o_ready
	task automatic bus_access(input logic rw, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge i_clock);
		i_request <= 1'b1;
		i_rw <= rw;
		i_address <= addr;
		i_wdata <= wdata;
		do begin
			@(posedge i_clock);
		end while (o_ready !== 1'b1);
		rdata = o_rdata;
		i_request <= 1'b0;
		access_count++;
	endtask

	function automatic bit in_ram(input logic [31:0] addr);
		return (addr >= soc_map_pkg::BANK_BASE && addr < soc_map_pkg::BANK_BASE + 32'h1000)
			|| (addr >= soc_map_pkg::SRAM_BASE
			&& addr < soc_map_pkg::SRAM_BASE + 32'(soc_map_pkg::SRAM_WORDS * 4));
	endfunction

	function automatic bit in_led(input logic [31:0] addr);
		return addr >= soc_map_pkg::LED_BASE
			&& addr < soc_map_pkg::LED_BASE + 32'(soc_map_pkg::LED_SPAN);
	endfunction

	// Access plus model update and checks
	task automatic run_access(input logic rw, input logic [31:0] addr,
		input logic [31:0] wdata);
		logic [31:0] rdata;
		logic [31:0] word;
		word = addr >> 2;
		bus_access(rw, addr, wdata, rdata);
		if (rw == soc_bus_pkg::BUS_WRITE) begin
			if (in_ram(addr)) begin
				model_mem[word] = wdata;
			end else if (in_led(addr)) begin
				led_model = wdata[soc_map_pkg::LED_W-1:0];
			end
		end else if (in_ram(addr)) begin
			if (model_mem.exists(word)) begin
				check_value(rdata, model_mem[word], $sformatf("read data at %h", addr));
			end
		end else begin
			check_value(rdata, 32'h0, $sformatf("zero read at %h", addr));
		end
		check_value(32'(o_ledr), 32'(led_model), $sformatf("o_ledr after access to %h", addr));
	endtask

	function automatic logic [31:0] bank_addr(input int bank, input int off);
		return soc_map_pkg::BANK_BASE + (32'(bank) << 10) + (32'(off) << 2);
	endfunction

	function automatic logic [31:0] sram_addr(input int word);
		return soc_map_pkg::SRAM_BASE + (32'(word) << 2);
	endfunction

	// Few words at both ends of a window so reads often hit written data
	function automatic int pick_offset(input int words);
		if ($urandom_range(0, 1) == 0) begin
			return $urandom_range(0, 3);
		end
		return $urandom_range(words - 4, words - 1);
	endfunction

	function automatic logic [31:0] unmapped_addr();
		case ($urandom_range(0, 2))
			0: return 32'h0000_1000 + ($urandom_range(0, 1023) << 2);
			1: return 32'h2000_0000 + ($urandom & 32'h0fff_fffc);
			default: return soc_map_pkg::LED_BASE + 32'(soc_map_pkg::LED_SPAN)
				+ ($urandom_range(0, 63) << 2);
		endcase
	endfunction

	function automatic logic [31:0] random_addr(input int region);
		case (region)
			0: return bank_addr($urandom_range(0, 3), pick_offset(soc_map_pkg::BANK_WORDS));
			1: return sram_addr(pick_offset(soc_map_pkg::SRAM_WORDS));
			2: return soc_map_pkg::LED_BASE + ($urandom_range(0, 3) << 2);
			default: return unmapped_addr();
		endcase
	endfunction

	initial begin
		void'($urandom(32'he665));
		i_request = 1'b0;
		i_rw = soc_bus_pkg::BUS_READ;
		i_address = '0;
		i_wdata = '0;
		wait (i_rst_n === 1'b1);
		@(posedge i_clock);
		check_value(32'(o_ready), 32'h0, "o_ready after reset");
		check_value(32'(o_ledr), 32'h0, "o_ledr after reset");

		run_access(soc_bus_pkg::BUS_WRITE, bank_addr(0, 0), 32'hcafe_0001);
		run_access(soc_bus_pkg::BUS_READ, bank_addr(0, 0), 32'h0);

		// Same offset in every bank with different data
		for (int k = 0; k < 4; k++) begin
			run_access(soc_bus_pkg::BUS_WRITE, bank_addr(k, 37), 32'h1111_1111 * (k + 1));
		end
		for (int k = 0; k < 4; k++) begin
			run_access(soc_bus_pkg::BUS_READ, bank_addr(k, 37), 32'h0);
		end
		repeat (N_BANK_OPS) begin
			run_access($urandom_range(0, 1), random_addr(0), $urandom);
		end

		// Halves of the 16-bit window must not swap
		run_access(soc_bus_pkg::BUS_WRITE, sram_addr(5), 32'ha5a5_1234);
		run_access(soc_bus_pkg::BUS_READ, sram_addr(5), 32'h0);
		repeat (N_SRAM_OPS) begin
			run_access($urandom_range(0, 1), random_addr(1), $urandom);
		end

		repeat (N_LED_PAIRS) begin
			run_access(soc_bus_pkg::BUS_WRITE, soc_map_pkg::LED_BASE, $urandom);
			run_access(soc_bus_pkg::BUS_READ, soc_map_pkg::LED_BASE + 32'h4, 32'h0);
		end

		// Unmapped writes reuse the low address bits of the words read back below
		for (int k = 0; k < N_UNMAPPED_PAIRS; k++) begin
			run_access(soc_bus_pkg::BUS_READ, unmapped_addr(), 32'h0);
			run_access(soc_bus_pkg::BUS_WRITE, bank_addr(k % 4, 37)
				+ (k < N_UNMAPPED_PAIRS / 2 ? 32'h0000_1000 : 32'h2000_0000), $urandom);
		end
		for (int k = 0; k < 4; k++) begin
			run_access(soc_bus_pkg::BUS_READ, bank_addr(k, 37), 32'h0);
		end

		repeat (N_MIXED_OPS) begin
			run_access($urandom_range(0, 1), random_addr($urandom_range(0, 3)), $urandom);
		end

		// Stray ready pulses would show up here
		repeat (3) @(posedge i_clock);
		check_value(32'(ready_count), 32'(access_count), "o_ready pulse count");
		if (dut.u_assert.fail_count != 0) begin
			error_count += dut.u_assert.fail_count;
			$display("The bus assertions failed %0d times", dut.u_assert.fail_count);
		end
		$display("Checks: %0d, accesses: %0d, errors: %0d", check_count, access_count,
			error_count);
		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Far more cycles than the slowest access needs
	initial begin
		repeat (20 * TOTAL_ACCESSES) @(posedge i_clock);
		$display("Timeout: the bus stopped answering after %0d of %0d accesses",
			access_count, TOTAL_ACCESSES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* soc_bus_top.f */
hdl/soc_bus_pkg.sv
hdl/soc_map_pkg.sv
hdl/bus_decoder.sv
hdl/bram_bank.sv
hdl/sram16_block.sv
hdl/memory_16_to_32.sv
hdl/led_register.sv
hdl/bus_response_mux.sv
hdl/soc_bus_top.sv
sim/clock_gen.sv
sim/soc_bus_assert.sv
sim/soc_bus_tb.sv
